// ==== files.f ====
logic/mem_pkg.sv
logic/sram_array.sv
logic/sram_controller.sv
logic/mem_align.sv
logic/main_mem_controller.sv
logic/main_memory_top.sv
tb/main_memory_tb.sv

// ==== logic/main_mem_controller.sv ====
`timescale 1ns/1ps

module main_mem_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  mem_pkg::mem_req_t req,
    input  logic              done,
    output mem_pkg::mem_req_t cmd,
    output logic              rd_start,
    output logic              wr_start,
    output logic              stage_load,
    output logic              ready
);

    mem_pkg::mem_state_e state;
    logic                accept;
    logic                direct;

    assign accept = (state == mem_pkg::ST_IDLE) && en;

    // Word writes skip the read phase.
    assign direct = !req.rd_wr && (req.size == mem_pkg::SIZE_WORD);

    // Request is held for the whole access.
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= mem_pkg::ST_IDLE;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            ready    <= 1'b0;
        end else begin
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            ready    <= 1'b0;
            case (state)
                mem_pkg::ST_IDLE: begin
                    if (en) begin
                        if (req.rd_wr) begin
                            state    <= mem_pkg::ST_READ;
                            rd_start <= 1'b1;
                        end else if (direct) begin
                            state    <= mem_pkg::ST_WRITE;
                            wr_start <= 1'b1;
                        end else begin
                            state    <= mem_pkg::ST_RMW_READ;
                            rd_start <= 1'b1;
                        end
                    end
                end
                mem_pkg::ST_READ: begin
                    if (done) state <= mem_pkg::ST_DONE;
                end
                mem_pkg::ST_RMW_READ: begin
                    if (done) begin
                        state    <= mem_pkg::ST_RMW_WRITE;
                        wr_start <= 1'b1; // Staged word is valid next cycle.
                    end
                end
                mem_pkg::ST_RMW_WRITE,
                mem_pkg::ST_WRITE: begin
                    if (done) state <= mem_pkg::ST_DONE;
                end
                mem_pkg::ST_DONE: begin
                    ready <= 1'b1;
                    state <= mem_pkg::ST_IDLE;
                end
                default: state <= mem_pkg::ST_IDLE;
            endcase
        end
    end

    // Capture the read word on the last cycle of every read phase.
    assign stage_load = done &&
        ((state == mem_pkg::ST_READ) || (state == mem_pkg::ST_RMW_READ));

    a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        ready |=> !ready)
        else $error("main_mem_controller: ready held for two cycles");

endmodule

// ==== logic/main_memory_top.sv ====
`timescale 1ns/1ps

module main_memory_top #(
    parameter int SRAM_CYCLES = 3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              en,
    input  mem_pkg::mem_req_t req,
    output logic              ready,
    output logic [31:0]       rd_data
);

    mem_pkg::mem_req_t   cmd;
    mem_pkg::sram_ctrl_t sram_ctrl;
    logic                rd_start;
    logic                wr_start;
    logic                sram_done;
    logic                stage_load;
    logic [31:0]         rd_word;
    logic [31:0]         staged_word;
    logic [31:0]         merged_word;

    main_mem_controller i_mem_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .req        (req),
        .done       (sram_done),
        .cmd        (cmd),
        .rd_start   (rd_start),
        .wr_start   (wr_start),
        .stage_load (stage_load),
        .ready      (ready)
    );

    sram_controller #(
        .SRAM_CYCLES (SRAM_CYCLES)
    ) i_sram_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_start  (rd_start),
        .wr_start  (wr_start),
        .sram_ctrl (sram_ctrl),
        .done      (sram_done)
    );

    sram_array i_array (
        .clk     (clk),
        .addr    (cmd.addr),
        .ctrl    (sram_ctrl),
        .wr_word (merged_word),
        .rd_word (rd_word)
    );

    // Staging register, also the read data output.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            staged_word <= '0;
        end else if (stage_load) begin
            staged_word <= rd_word;
        end
    end

    mem_align i_align (
        .staged      (staged_word),
        .size        (cmd.size),
        .offset      (cmd.addr[1:0]),
        .wr_data     (cmd.wr_data),
        .merged_word (merged_word)
    );

    assign rd_data = staged_word;

endmodule

// ==== logic/mem_align.sv ====
`timescale 1ns/1ps

module mem_align (
    input  logic               [31:0] staged,
    input  mem_pkg::mem_size_e        size,
    input  logic               [1:0]  offset,
    input  logic               [31:0] wr_data,
    output logic               [31:0] merged_word
);

    always_comb begin
        merged_word = staged; // Untouched lanes keep their old value.
        case (size)
            mem_pkg::SIZE_WORD: begin
                merged_word = wr_data;
            end
            mem_pkg::SIZE_BYTE: begin
                merged_word[offset*8 +: 8] = wr_data[7:0];
            end
            mem_pkg::SIZE_HALF: begin
                // Bit 0 of the offset is ignored.
                if (offset[1]) begin
                    merged_word[31:16] = wr_data[15:0];
                end else begin
                    merged_word[15:0] = wr_data[15:0];
                end
            end
            default: begin
                merged_word = staged;
            end
        endcase
    end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    localparam int ADDR_W = 15; // 32 KB byte address.

    // Write size encoding.
    typedef enum logic [1:0] {
        SIZE_WORD = 2'd0,
        SIZE_BYTE = 2'd1,
        SIZE_HALF = 2'd2
    } mem_size_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              rd_wr;   // High for read.
        mem_size_e         size;
        logic [31:0]       wr_data;
    } mem_req_t;

    // SRAM strobes, active high.
    typedef struct packed {
        logic ce;
        logic oe;
        logic we;
    } sram_ctrl_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_RMW_READ,
        ST_RMW_WRITE,
        ST_WRITE,
        ST_DONE
    } mem_state_e;

    typedef enum logic {
        SR_IDLE,
        SR_ACCESS
    } sram_state_e;

endpackage

// ==== logic/sram_array.sv ====
`timescale 1ns/1ps

module sram_array (
    input  logic                      clk,
    input  logic [mem_pkg::ADDR_W-1:0] addr,
    input  mem_pkg::sram_ctrl_t       ctrl,
    input  logic [31:0]               wr_word,
    output logic [31:0]               rd_word
);

    // Eight groups of 32 banks, each bank 32 words deep.
    logic [31:0] mem [0:7][0:31][0:31];

    logic [2:0] grp;
    logic [4:0] bank;
    logic [4:0] word;

    assign grp  = addr[14:12];
    assign bank = addr[11:7];
    assign word = addr[6:2]; // Low two bits select a byte lane, not a word.

    always_ff @(posedge clk) begin
        if (ctrl.ce && ctrl.we) begin
            mem[grp][bank][word] <= wr_word;
        end
    end

    // Outputs float low when the selected bank is not driving.
    always_comb begin
        if (ctrl.ce && ctrl.oe) begin
            rd_word = mem[grp][bank][word];
        end else begin
            rd_word = '0;
        end
    end

    a_we_needs_ce: assert property (@(posedge clk) ctrl.we |-> ctrl.ce)
        else $error("sram_array: write enable without chip enable");

endmodule

// ==== logic/sram_controller.sv ====
`timescale 1ns/1ps

module sram_controller #(
    parameter int SRAM_CYCLES = 3
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_start,
    input  logic                wr_start,
    output mem_pkg::sram_ctrl_t sram_ctrl,
    output logic                done
);

    localparam int CNT_W = (SRAM_CYCLES > 1) ? $clog2(SRAM_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(SRAM_CYCLES - 1);

    mem_pkg::sram_state_e state;
    logic [CNT_W-1:0]     cnt;
    logic                 is_wr; // Current access is a write.
    logic                 active;
    logic                 last;

    assign active = (state == mem_pkg::SR_ACCESS);
    assign last   = active && (cnt == LAST_CNT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_pkg::SR_IDLE;
            cnt   <= '0;
            is_wr <= 1'b0;
        end else begin
            case (state)
                mem_pkg::SR_IDLE: begin
                    if (rd_start || wr_start) begin
                        state <= mem_pkg::SR_ACCESS;
                        cnt   <= '0;
                        is_wr <= wr_start;
                    end
                end
                mem_pkg::SR_ACCESS: begin
                    if (last) begin
                        state <= mem_pkg::SR_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= mem_pkg::SR_IDLE;
            endcase
        end
    end

    // Write strobe only in the final cycle so the array commits once.
    assign sram_ctrl.ce = active;
    assign sram_ctrl.oe = active && !is_wr;
    assign sram_ctrl.we = last && is_wr;
    assign done         = last;

    a_start_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_start && wr_start))
        else $error("sram_controller: read and write start together");

    a_oe_we_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(sram_ctrl.oe && sram_ctrl.we))
        else $error("sram_controller: oe and we both high");

    a_start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_start || wr_start) |-> (state == mem_pkg::SR_IDLE))
        else $error("sram_controller: start pulse during an access");

endmodule

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --assert --top-module main_memory_tb -f files.f -o main_memory_sim \
    && ./obj_dir/main_memory_sim | tee /dev/stderr \
        | grep "Simulation completed successfully" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== tb/main_memory_golden.txt ====
// op addr size wdata expect (op 0 write, 1 read, 2 read with a word write strobe mid-access)
// op 2 sends its intruding write to the address in wdata; expect is read data or held rd_data
0 0000 0 11223344 00000000
0 1084 0 A5A55A5A 00000000
0 7FFD 0 CAFEF00D 00000000
0 2A48 0 0BADC0DE 00000000
1 0000 0 00000000 11223344
1 1084 0 00000000 A5A55A5A
1 7FFC 0 00000000 CAFEF00D
1 2A48 0 00000000 0BADC0DE
0 3000 0 12345678 0BADC0DE
0 3004 0 87654321 0BADC0DE
0 3000 1 000000AA 00000000
0 3001 1 000000BB 00000000
0 3002 1 FFFFFFCC 00000000
0 3003 1 000000DD 00000000
1 3000 0 00000000 DDCCBBAA
0 3006 2 0000BEEF 00000000
0 3005 2 1234CAFE 00000000
1 3004 0 00000000 BEEFCAFE
2 0000 0 00001084 11223344
1 1084 0 00000000 A5A55A5A
0 5000 0 01010101 A5A55A5A
1 5000 0 00000000 01010101

// ==== tb/main_memory_tb.sv ====
`timescale 1ns/1ps

module main_memory_tb;

    localparam int SRAM_CYCLES = 3;
    localparam int MAX_REC     = 64;
    localparam int REC_W       = 5; // Columns per record in the golden file.

    logic              clk;
    logic              rst_n;
    logic              en;
    mem_pkg::mem_req_t req;
    logic              ready;
    logic [31:0]       rd_data;

    logic [31:0] golden [0:MAX_REC*REC_W-1];
    int          n_rec;
    int          errors;
    int          limit;
    int          cycles;

    main_memory_top #(
        .SRAM_CYCLES (SRAM_CYCLES)
    ) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .req     (req),
        .ready   (ready),
        .rd_data (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Watchdog on the whole run.
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        errors++;
        $display("Timeout after %0d cycles, a command never completed", cycles);
        $display("Errors: %0d", errors);
        $display("Simulation failed");
        $finish;
    end

    // Cycles from the edge that samples en to the edge that raises ready.
    function automatic int expected_latency(input logic [31:0] op, input logic [31:0] size);
        if (op != 0 || mem_pkg::mem_size_e'(size[1:0]) == mem_pkg::SIZE_WORD) begin
            return SRAM_CYCLES + 2;
        end
        return 2 * SRAM_CYCLES + 3; // Read phase plus write phase.
    endfunction

    task automatic check_idle_outputs(input string phase);
        assert (ready == 1'b0) else begin
            errors++;
            $display("FAIL ready %s expected %h actual %h", phase, 1'b0, ready);
        end
        assert (rd_data == 32'h0) else begin
            errors++;
            $display("FAIL rd_data %s expected %h actual %h", phase, 32'h0, rd_data);
        end
    endtask

    task automatic run_command(input int idx);
        logic [31:0] op;
        logic [31:0] expect_word;
        logic        busy_read;
        logic        word_wr;
        int          lat;
        int          base;
        int          exp_lat;
        base        = idx * REC_W;
        op          = golden[base];
        expect_word = golden[base + 4];
        busy_read   = (op == 32'd2);
        word_wr     = (op == 32'd0) && (golden[base + 2][1:0] == 2'd0);
        exp_lat     = expected_latency(op, golden[base + 2]);

        req.addr    = golden[base + 1][mem_pkg::ADDR_W-1:0];
        req.rd_wr   = (op != 32'd0);
        req.size    = mem_pkg::mem_size_e'(golden[base + 2][1:0]);
        req.wr_data = golden[base + 3];
        en          = 1'b1;
        lat         = 0;
        do begin
            @(negedge clk);
            lat++;
            if (busy_read && lat == 2) begin
                // Word write to another address while the read is in flight.
                req.addr    = golden[base + 3][mem_pkg::ADDR_W-1:0];
                req.rd_wr   = 1'b0;
                req.size    = mem_pkg::SIZE_WORD;
                req.wr_data = 32'h0BAD_0BAD;
                en          = 1'b1;
            end else begin
                en = 1'b0;
            end
        end while (!ready);

        assert ((lat - 1) == exp_lat) else begin
            errors++;
            $display("FAIL ready latency record %0d expected %h actual %h",
                     idx, exp_lat, lat - 1);
        end
        if (op != 32'd0 || word_wr) begin
            assert (rd_data == expect_word) else begin
                errors++;
                $display("FAIL rd_data record %0d expected %h actual %h",
                         idx, expect_word, rd_data);
            end
        end
    endtask

    initial begin
        int idle;
        rst_n  = 1'b0;
        en     = 1'b0;
        req    = '0;
        errors = 0;
        void'($urandom(32'h704));

        for (int i = 0; i < MAX_REC * REC_W; i++) begin
            golden[i] = 32'hFFFF_0000 | 32'(i); // Op column never reaches FFFF.
        end
        $readmemh("tb/main_memory_golden.txt", golden);
        n_rec = 0;
        while (n_rec < MAX_REC && golden[n_rec * REC_W][31:16] != 16'hFFFF) begin
            n_rec++;
        end
        limit = (n_rec + 2) * (2 * SRAM_CYCLES + 10) + 50;
        if (n_rec == 0) begin
            errors++;
            $display("No records found in the golden file");
        end

        repeat (5) begin
            @(negedge clk);
            check_idle_outputs("during reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs("after reset");

        for (int i = 0; i < n_rec; i++) begin
            idle = $urandom % 4;
            repeat (idle) @(negedge clk);
            run_command(i);
        end

        repeat (2) @(negedge clk);
        $display("Records: %0d, errors: %0d", n_rec, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
